/* logic/fetch_pkg.sv */
// Fetch path package with shared widths, vector types and the fetch state encoding
`default_nettype none

package fetch_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Byte address and PC width
  localparam int ADDR_W = 32;

  // Uncompressed instruction word
  localparam int INSTR_W = 32;

  // Prefetch entries, power of two
  localparam int FIFO_DEPTH = 4;

  // Granted requests still waiting for rvalid
  localparam int MAX_OUTSTANDING = 2;

  ////////////////////
  // Vector types
  ////////////////////

  // Byte address or program counter
  typedef logic [ADDR_W-1:0] addr_t;

  // Raw instruction word as returned by the bus
  typedef logic [INSTR_W-1:0] instr_t;

  // FIFO fill or free count, 0 to FIFO_DEPTH
  typedef logic [2:0] fifo_cnt_t;

  // Outstanding or discard count, 0 to MAX_OUTSTANDING
  typedef logic [1:0] outst_cnt_t;

  ////////////////////
  // State machines
  ////////////////////

  // Fetch enable latch
  // Leaves IDLE once and never returns
  typedef enum logic {
    FETCH_IDLE,
    FETCH_RUN
  } fetch_state_e;

endpackage

`default_nettype wire

/* logic/fetch_unit.sv */
// Fetch unit issuing OBI instruction requests and pushing kept responses to the prefetch FIFO
`default_nettype none

module fetch_unit (
  input  logic                  clk_i,
  input  logic                  rst_i,

  // Static boot vector
  input  fetch_pkg::addr_t      boot_addr_i,
  input  logic                  fetch_enable_i,

  // Taken jump or branch
  input  logic                  branch_i,
  input  fetch_pkg::addr_t      branch_addr_i,

  // OBI instruction port
  output logic                  instr_req_o,
  output fetch_pkg::addr_t      instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  fetch_pkg::instr_t     instr_rdata_i,
  input  logic                  instr_err_i,

  // Prefetch FIFO write side
  input  fetch_pkg::fifo_cnt_t  fifo_free_i,
  output logic                  push_o,
  output fetch_pkg::instr_t     push_data_o,
  output logic                  push_err_o
);
  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;
  addr_t        pc_q;
  addr_t        pc_d;
  addr_t        tgt_q;
  logic         redir_pend_q;
  logic         redir_pend_d;
  logic         hold_q;
  outst_cnt_t   outst_q;
  outst_cnt_t   outst_d;
  outst_cnt_t   discard_q;
  outst_cnt_t   discard_d;
  logic         push_q;
  instr_t       push_data_q;
  logic         push_err_q;
  logic         grant;
  logic         rsp_drop;
  logic         rsp_keep;
  logic         can_req;
  fifo_cnt_t    committed;

  ////////////////////
  // Request side
  ////////////////////

  // Slots already promised in the FIFO
  // A registered push still counts until the FIFO sees it
  assign committed = fifo_cnt_t'(outst_q) + fifo_cnt_t'(push_q);

  assign can_req = (outst_q < outst_cnt_t'(MAX_OUTSTANDING)) && (committed < fifo_free_i);

  // Once raised, req stays up until granted
  assign instr_req_o  = (state_q == FETCH_RUN) && (hold_q || can_req);
  assign instr_addr_o = pc_q;

  assign grant = instr_req_o && instr_gnt_i;

  // Enable latch
  always_comb begin
    state_d = state_q;
    if ((state_q == FETCH_IDLE) && fetch_enable_i) begin
      state_d = FETCH_RUN;
    end
  end

  // Request PC
  // A redirect during an ungranted request waits for that grant
  always_comb begin
    pc_d         = pc_q;
    redir_pend_d = redir_pend_q;
    if (branch_i) begin
      if (instr_req_o && !instr_gnt_i) begin
        redir_pend_d = 1'b1;
      end else begin
        pc_d         = branch_addr_i;
        redir_pend_d = 1'b0;
      end
    end else if (grant) begin
      pc_d         = redir_pend_q ? tgt_q : pc_q + 32'd4;
      redir_pend_d = 1'b0;
    end
  end

  ////////////////////
  // Response side
  ////////////////////

  // Old stream responses, including any in the redirect cycle
  assign rsp_drop = instr_rvalid_i && ((discard_q != '0) || branch_i);
  assign rsp_keep = instr_rvalid_i && !rsp_drop;

  assign outst_d = outst_q + outst_cnt_t'(grant) - outst_cnt_t'(instr_rvalid_i);

  // Discard bookkeeping
  always_comb begin
    if (branch_i) begin
      // Everything still in flight after this cycle is stale
      discard_d = outst_d;
    end else begin
      discard_d = discard_q;
      if (instr_rvalid_i && (discard_q != '0)) begin
        discard_d = discard_d - 2'd1;
      end
      // Grant of the held pre-redirect request
      if (grant && redir_pend_q) begin
        discard_d = discard_d + 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= FETCH_IDLE;
      pc_q         <= boot_addr_i;
      redir_pend_q <= 1'b0;
      hold_q       <= 1'b0;
      outst_q      <= '0;
      discard_q    <= '0;
      push_q       <= 1'b0;
    end else begin
      state_q      <= state_d;
      pc_q         <= pc_d;
      redir_pend_q <= redir_pend_d;
      hold_q       <= instr_req_o && !instr_gnt_i;
      outst_q      <= outst_d;
      discard_q    <= discard_d;
      push_q       <= rsp_keep;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (branch_i) begin
      tgt_q <= branch_addr_i;
    end
    push_data_q <= instr_rdata_i;
    push_err_q  <= instr_err_i;
  end

  assign push_o      = push_q;
  assign push_data_o = push_data_q;
  assign push_err_o  = push_err_q;

endmodule

`default_nettype wire

/* logic/prefetch_fifo.sv */
// Prefetch FIFO holding fetched words with their bus error flag
`default_nettype none

module prefetch_fifo (
  input  logic                  clk_i,
  input  logic                  rst_i,

  // Redirect clears all entries
  input  logic                  flush_i,

  // Write side from the fetch unit
  input  logic                  push_i,
  input  fetch_pkg::instr_t     push_data_i,
  input  logic                  push_err_i,
  output fetch_pkg::fifo_cnt_t  free_o,

  // Read side to the issue stage
  output logic                  pop_valid_o,
  input  logic                  pop_ready_i,
  output fetch_pkg::instr_t     pop_data_o,
  output logic                  pop_err_o
);
  import fetch_pkg::*;

  instr_t                          data_mem [FIFO_DEPTH];
  logic                            err_mem  [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr_q;
  fifo_cnt_t                       cnt_q;
  logic                            push_en;
  logic                            pop_en;

  ////////////////////
  // Handshakes
  ////////////////////

  // Push during flush belongs to the old stream
  assign push_en = push_i && !flush_i && (cnt_q != fifo_cnt_t'(FIFO_DEPTH));
  assign pop_en  = pop_valid_o && pop_ready_i && !flush_i;

  assign pop_valid_o = (cnt_q != '0);
  assign free_o      = fifo_cnt_t'(FIFO_DEPTH) - cnt_q;

  // Head entry
  assign pop_data_o = data_mem[rd_ptr_q];
  assign pop_err_o  = err_mem[rd_ptr_q];

  ////////////////////
  // Pointers
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Pointers wrap, depth is a power of two
      if (push_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + fifo_cnt_t'(push_en) - fifo_cnt_t'(pop_en);
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      data_mem[wr_ptr_q] <= push_data_i;
      err_mem[wr_ptr_q]  <= push_err_i;
    end
  end

endmodule

`default_nettype wire

/* logic/instr_issue.sv */
// Issue stage handing each fetched word to the decoder with its PC and flags
`default_nettype none

module instr_issue (
  input  logic               clk_i,
  input  logic               rst_i,

  input  fetch_pkg::addr_t   boot_addr_i,

  // Redirect
  input  logic               branch_i,
  input  fetch_pkg::addr_t   branch_addr_i,

  // Prefetch FIFO read side
  input  logic               pop_valid_i,
  input  fetch_pkg::instr_t  pop_data_i,
  input  logic               pop_err_i,
  output logic               pop_ready_o,

  // Decoder side
  output logic               instr_valid_o,
  input  logic               instr_ready_i,
  output fetch_pkg::instr_t  instr_o,
  output fetch_pkg::addr_t   pc_o,
  output logic               instr_err_o,
  output logic               illegal_o
);
  import fetch_pkg::*;

  addr_t   issue_pc_q;
  logic    out_valid_q;
  instr_t  out_instr_q;
  addr_t   out_pc_q;
  logic    out_err_q;
  logic    out_illegal_q;
  logic    take;

  ////////////////////
  // Pop control
  ////////////////////

  // Room when empty or drained this cycle
  // No pop while the FIFO flushes
  assign pop_ready_o = !branch_i && (!out_valid_q || instr_ready_i);
  assign take        = pop_valid_i && pop_ready_o;

  // Issue PC and valid flag
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      issue_pc_q  <= boot_addr_i;
      out_valid_q <= 1'b0;
    end else if (branch_i) begin
      // Held word is from the old stream
      issue_pc_q  <= branch_addr_i;
      out_valid_q <= 1'b0;
    end else begin
      if (take) begin
        issue_pc_q  <= issue_pc_q + 32'd4;
        out_valid_q <= 1'b1;
      end else if (instr_ready_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  // Loads only on take, so it holds while stalled
  always_ff @(posedge clk_i) begin
    if (take) begin
      out_instr_q   <= pop_data_i;
      out_pc_q      <= issue_pc_q;
      out_err_q     <= pop_err_i;
      // Compressed encodings are not supported
      out_illegal_q <= (pop_data_i[1:0] != 2'b11);
    end
  end

  assign instr_valid_o = out_valid_q;
  assign instr_o       = out_instr_q;
  assign pc_o          = out_pc_q;
  assign instr_err_o   = out_err_q;
  assign illegal_o     = out_illegal_q;

endmodule

`default_nettype wire

/* logic/fetch_top.sv */
// Instruction fetch top joining fetch unit, prefetch FIFO and issue stage
`default_nettype none

module fetch_top (
  input  logic               clk_i,
  input  logic               rst_i,

  // Boot and fetch enable
  input  fetch_pkg::addr_t   boot_addr_i,
  input  logic               fetch_enable_i,

  // Taken jump or branch
  input  logic               branch_i,
  input  fetch_pkg::addr_t   branch_addr_i,

  // OBI instruction port
  output logic               instr_req_o,
  input  logic               instr_gnt_i,
  output fetch_pkg::addr_t   instr_addr_o,
  input  logic               instr_rvalid_i,
  input  fetch_pkg::instr_t  instr_rdata_i,
  input  logic               instr_err_i,

  // Decoder handshake
  output logic               instr_valid_o,
  input  logic               instr_ready_i,
  output fetch_pkg::instr_t  instr_o,
  output fetch_pkg::addr_t   pc_o,
  output logic               instr_err_o,
  output logic               illegal_o
);
  import fetch_pkg::*;

  // Fetch unit to FIFO
  fifo_cnt_t  fifo_free;
  logic       push;
  instr_t     push_data;
  logic       push_err;

  // FIFO to issue stage
  logic       pop_valid;
  logic       pop_ready;
  instr_t     pop_data;
  logic       pop_err;

  ////////////////////
  // Producer
  ////////////////////

  fetch_unit fetch_unit_inst (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .branch_i       ( branch_i       ),
    .branch_addr_i  ( branch_addr_i  ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .instr_err_i    ( instr_err_i    ),
    .fifo_free_i    ( fifo_free      ),
    .push_o         ( push           ),
    .push_data_o    ( push_data      ),
    .push_err_o     ( push_err       )
  );

  // Flushed by the same redirect
  prefetch_fifo prefetch_fifo_inst (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .flush_i     ( branch_i  ),
    .push_i      ( push      ),
    .push_data_i ( push_data ),
    .push_err_i  ( push_err  ),
    .free_o      ( fifo_free ),
    .pop_valid_o ( pop_valid ),
    .pop_ready_i ( pop_ready ),
    .pop_data_o  ( pop_data  ),
    .pop_err_o   ( pop_err   )
  );

  ////////////////////
  // Consumer
  ////////////////////

  instr_issue instr_issue_inst (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .boot_addr_i   ( boot_addr_i   ),
    .branch_i      ( branch_i      ),
    .branch_addr_i ( branch_addr_i ),
    .pop_valid_i   ( pop_valid     ),
    .pop_data_i    ( pop_data      ),
    .pop_err_i     ( pop_err       ),
    .pop_ready_o   ( pop_ready     ),
    .instr_valid_o ( instr_valid_o ),
    .instr_ready_i ( instr_ready_i ),
    .instr_o       ( instr_o       ),
    .pc_o          ( pc_o          ),
    .instr_err_o   ( instr_err_o   ),
    .illegal_o     ( illegal_o     )
  );

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
// Clock and reset generator for the fetch path testbench
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 16,
  parameter int DRIVE_DELAY  = 10
) (
  output logic clk_o,
  output logic rst_o
);

  // Free running clock
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2);
      clk_o = ~clk_o;
    end
  end

  // Reset released just after the last reset edge
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #DRIVE_DELAY;
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

/* tests/tb_instr_mem.sv */
// Instruction memory model with random grants and in-order responses computed from the address
`default_nettype none

module tb_instr_mem #(
  parameter int          SEED         = 1,
  parameter logic [29:0] DATA_PATTERN = '0,
  parameter int          DRIVE_DELAY  = 10
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               req_i,
  input  fetch_pkg::addr_t   addr_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output fetch_pkg::instr_t  rdata_o,
  output logic               err_o
);
  import fetch_pkg::*;

  integer  seed;
  int      cycle;
  int      last_due;
  addr_t   addr_q [$];
  int      due_q  [$];

  // Word address XOR pattern, low bits mark the compressed slots
  function automatic instr_t data_at(input addr_t a);
    logic [1:0] low;
    low = (a[5:2] == 4'hF) ? 2'b01 : 2'b11;
    return {a[31:2] ^ DATA_PATTERN, low};
  endfunction

  initial begin
    seed     = SEED;
    cycle    = 0;
    last_due = 0;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
  end

  ////////////////////
  // Request side
  ////////////////////

  // Mid-cycle sample, accepted at the coming edge
  always @(negedge clk_i) begin
    int lat;
    int due;
    if (rst_i) begin
      addr_q.delete();
      due_q.delete();
      last_due = 0;
    end else if (req_i && gnt_o) begin
      // 1 to 3 cycles until rvalid
      lat = 1 + int'($unsigned($random(seed)) % 3);
      due = cycle + lat;
      // Keep order, one response per cycle
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      addr_q.push_back(addr_i);
      due_q.push_back(due);
    end
  end

  ////////////////////
  // Response side
  ////////////////////

  always @(posedge clk_i) begin
    cycle = cycle + 1;
    #DRIVE_DELAY;
    // Grant about three cycles in four
    gnt_o    = (($random(seed) & 3) != 0);
    rvalid_o = 1'b0;
    if ((due_q.size() != 0) && (due_q[0] == cycle)) begin
      rvalid_o = 1'b1;
      rdata_o  = data_at(addr_q[0]);
      // Error region at bits 11:8 == E
      err_o    = (addr_q[0][11:8] == 4'hE);
      void'(addr_q.pop_front());
      void'(due_q.pop_front());
    end
  end

endmodule

`default_nettype wire

/* tests/tb_fetch_top.sv */
// Testbench for the fetch path with random bus timing, back-pressure and redirects
`default_nettype none

module tb_fetch_top;
  import fetch_pkg::*;

  ////////////////////
  // Run constants
  ////////////////////

  localparam int          SEED         = 63101;
  localparam int          CLK_PERIOD   = 100;
  localparam int          RESET_CYCLES = 16;
  localparam int          DRIVE_DELAY  = 10;
  localparam addr_t       BOOT_ADDR    = 32'h0000_0080;
  // Range covering the error region and several compressed slots
  localparam addr_t       FLAG_BASE    = 32'h0000_0DC0;
  localparam logic [29:0] DATA_PATTERN = 30'h2A5C_3E91;
  localparam int          IDLE_CYCLES  = 8;
  localparam int          SEQ_COUNT    = 200;
  localparam int          STALL_COUNT  = 300;
  localparam int          REDIR_COUNT  = 300;
  localparam int          FLAG_COUNT   = 128;
  // Average cycles between redirects
  localparam int          BRANCH_RATE  = 12;
  localparam int          CPI_BOUND    = 32;
  localparam int          WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CYCLES
    + CPI_BOUND * (SEQ_COUNT + STALL_COUNT + REDIR_COUNT + FLAG_COUNT);

  logic    clk;
  logic    rst;
  logic    fetch_enable;
  logic    branch;
  addr_t   branch_addr;
  logic    instr_req;
  addr_t   instr_addr;
  logic    instr_gnt;
  logic    instr_rvalid;
  instr_t  instr_rdata;
  logic    instr_err;
  logic    instr_ready;
  logic    instr_valid;
  instr_t  instr;
  addr_t   pc;
  logic    instr_err_out;
  logic    illegal;

  // Scoreboard and bookkeeping
  integer  seed;
  string   test_name;
  int      errors;
  int      checks;
  int      tests_run;
  int      tests_failed;
  int      errors_at_start;
  int      accepted;
  int      outstanding;
  int      stalls;
  int      busy_redirects;
  int      illegal_seen;
  int      err_seen;
  logic    enable_req;
  addr_t   exp_pc;
  logic    held_valid;
  instr_t  held_instr;
  addr_t   held_pc;
  logic    held_err;
  logic    held_illegal;

  tb_clock_gen #(
    .PERIOD       ( CLK_PERIOD   ),
    .RESET_CYCLES ( RESET_CYCLES ),
    .DRIVE_DELAY  ( DRIVE_DELAY  )
  ) clock_gen_inst (
    .clk_o ( clk ),
    .rst_o ( rst )
  );

  tb_instr_mem #(
    .SEED         ( SEED         ),
    .DATA_PATTERN ( DATA_PATTERN ),
    .DRIVE_DELAY  ( DRIVE_DELAY  )
  ) instr_mem_inst (
    .clk_i    ( clk          ),
    .rst_i    ( rst          ),
    .req_i    ( instr_req    ),
    .addr_i   ( instr_addr   ),
    .gnt_o    ( instr_gnt    ),
    .rvalid_o ( instr_rvalid ),
    .rdata_o  ( instr_rdata  ),
    .err_o    ( instr_err    )
  );

  fetch_top fetch_top_inst (
    .clk_i          ( clk           ),
    .rst_i          ( rst           ),
    .boot_addr_i    ( BOOT_ADDR     ),
    .fetch_enable_i ( fetch_enable  ),
    .branch_i       ( branch        ),
    .branch_addr_i  ( branch_addr   ),
    .instr_req_o    ( instr_req     ),
    .instr_gnt_i    ( instr_gnt     ),
    .instr_addr_o   ( instr_addr    ),
    .instr_rvalid_i ( instr_rvalid  ),
    .instr_rdata_i  ( instr_rdata   ),
    .instr_err_i    ( instr_err     ),
    .instr_valid_o  ( instr_valid   ),
    .instr_ready_i  ( instr_ready   ),
    .instr_o        ( instr         ),
    .pc_o           ( pc            ),
    .instr_err_o    ( instr_err_out ),
    .illegal_o      ( illegal       )
  );

  ////////////////////
  // Reference model
  ////////////////////

  // Upper 30 bits from the word address and low bits 01 in slot F of each 64 bytes
  function automatic instr_t word_for(input addr_t a);
    logic [1:0] low;
    low = (a[5:2] == 4'hF) ? 2'b01 : 2'b11;
    return {a[31:2] ^ DATA_PATTERN, low};
  endfunction

  function automatic logic err_for(input addr_t a);
    return (a[11:8] == 4'hE);
  endfunction

  function automatic logic illegal_for(input addr_t a);
    return (a[5:2] == 4'hF);
  endfunction

  ////////////////////
  // Reporting
  ////////////////////

  task automatic value_error(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    errors = errors + 1;
    $display("[ERROR] %s: %s expected %h, actual %h", test_name, what, expected, actual);
  endtask

  task automatic plain_error(input string msg);
    errors = errors + 1;
    $display("[ERROR] %s: %s", test_name, msg);
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    tests_run = tests_run + 1;
    if (errors != errors_at_start) begin
      tests_failed = tests_failed + 1;
      $display("[FAIL] %s: %0d errors", test_name, errors - errors_at_start);
    end else begin
      $display("[PASS] %s", test_name);
    end
  endtask

  ////////////////////
  // Per-cycle checks
  ////////////////////

  // Granted minus answered as counted at the coming edge
  task automatic track_bus(input logic do_branch);
    if ((instr_req === 1'b1) && (instr_gnt === 1'b1)) begin
      outstanding = outstanding + 1;
    end
    if (instr_rvalid === 1'b1) begin
      outstanding = outstanding - 1;
    end
    if (outstanding > MAX_OUTSTANDING) begin
      value_error("outstanding requests", MAX_OUTSTANDING, outstanding);
    end
    if (do_branch && (outstanding > 0)) begin
      busy_redirects = busy_redirects + 1;
    end
  endtask

  // Stalled output must not move
  task automatic check_hold();
    if (held_valid) begin
      checks = checks + 1;
      if (instr_valid !== 1'b1) begin
        plain_error("instr_valid_o dropped while the decoder stalled");
      end
      if (instr !== held_instr) begin
        value_error("held instr_o", held_instr, instr);
      end
      if (pc !== held_pc) begin
        value_error("held pc_o", held_pc, pc);
      end
      if ({instr_err_out, illegal} !== {held_err, held_illegal}) begin
        value_error("held flags", {held_err, held_illegal}, {instr_err_out, illegal});
      end
    end
  endtask

  task automatic check_accepted();
    checks = checks + 1;
    if (pc !== exp_pc) begin
      value_error("pc_o", exp_pc, pc);
    end
    if (instr !== word_for(exp_pc)) begin
      value_error("instr_o", word_for(exp_pc), instr);
    end
    if (instr_err_out !== err_for(exp_pc)) begin
      value_error("instr_err_o", err_for(exp_pc), instr_err_out);
    end
    if (illegal !== illegal_for(exp_pc)) begin
      value_error("illegal_o", illegal_for(exp_pc), illegal);
    end
    if (illegal === 1'b1) begin
      illegal_seen = illegal_seen + 1;
    end
    if (instr_err_out === 1'b1) begin
      err_seen = err_seen + 1;
    end
    accepted = accepted + 1;
    exp_pc   = exp_pc + 32'd4;
  endtask

  // One clock cycle with drive after the edge and sample mid-cycle
  task automatic step(input logic ready_val, input logic do_branch, input addr_t target);
    @(posedge clk);
    #DRIVE_DELAY;
    fetch_enable = enable_req;
    branch       = do_branch;
    branch_addr  = target;
    // Decoder takes nothing in a squash cycle
    instr_ready  = ready_val && !do_branch;
    @(negedge clk);
    track_bus(do_branch);
    check_hold();
    held_valid = 1'b0;
    if (do_branch) begin
      exp_pc = target;
    end else if ((instr_valid === 1'b1) && (instr_ready === 1'b1)) begin
      check_accepted();
    end else if (instr_valid === 1'b1) begin
      held_valid   = 1'b1;
      held_instr   = instr;
      held_pc      = pc;
      held_err     = instr_err_out;
      held_illegal = illegal;
      stalls       = stalls + 1;
    end
  endtask

  // Runs until count more words are taken by the decoder
  task automatic run_instructions(input int count, input logic random_ready,
                                  input int branch_rate);
    int    target_cnt;
    logic  ready_val;
    logic  do_branch;
    addr_t target;
    target_cnt = accepted + count;
    while (accepted < target_cnt) begin
      ready_val = random_ready ? (($random(seed) & 3) != 0) : 1'b1;
      do_branch = (branch_rate != 0) && (($unsigned($random(seed)) % branch_rate) == 0);
      target    = addr_t'($random(seed)) & 32'hFFFF_FFFC;
      step(ready_val, do_branch, target);
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    int    exp_illegal;
    int    exp_err;
    addr_t a;
    seed           = SEED;
    errors         = 0;
    checks         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    accepted       = 0;
    outstanding    = 0;
    stalls         = 0;
    busy_redirects = 0;
    illegal_seen   = 0;
    err_seen       = 0;
    held_valid     = 1'b0;
    enable_req     = 1'b0;
    exp_pc         = BOOT_ADDR;
    fetch_enable   = 1'b0;
    branch         = 1'b0;
    branch_addr    = '0;
    instr_ready    = 1'b0;

    // Through reset and a few idle cycles with fetch still disabled
    start_test("reset");
    do begin
      step(1'b0, 1'b0, '0);
      checks = checks + 1;
      if (instr_req !== 1'b0) begin
        value_error("instr_req_o in reset", 0, instr_req);
      end
      if (instr_valid !== 1'b0) begin
        value_error("instr_valid_o in reset", 0, instr_valid);
      end
    end while (rst === 1'b1);
    repeat (IDLE_CYCLES) begin
      step(1'b0, 1'b0, '0);
      checks = checks + 1;
      if (instr_req !== 1'b0) begin
        value_error("instr_req_o while disabled", 0, instr_req);
      end
      if (instr_valid !== 1'b0) begin
        value_error("instr_valid_o while disabled", 0, instr_valid);
      end
      if (instr_addr !== BOOT_ADDR) begin
        value_error("instr_addr_o while disabled", BOOT_ADDR, instr_addr);
      end
    end
    finish_test();

    start_test("sequential fetch");
    enable_req = 1'b1;
    run_instructions(SEQ_COUNT, 1'b0, 0);
    finish_test();

    start_test("back-pressure");
    stalls = 0;
    run_instructions(STALL_COUNT, 1'b1, 0);
    if (stalls == 0) begin
      plain_error("the decoder never stalled a valid output");
    end
    finish_test();

    start_test("redirect");
    run_instructions(REDIR_COUNT, 1'b1, BRANCH_RATE);
    if (busy_redirects == 0) begin
      plain_error("no redirect was made while responses were outstanding");
    end
    finish_test();

    // Jump into the flag range and count both kinds of flagged words
    start_test("flags");
    step(1'b0, 1'b1, FLAG_BASE);
    illegal_seen = 0;
    err_seen     = 0;
    run_instructions(FLAG_COUNT, 1'b1, 0);
    exp_illegal = 0;
    exp_err     = 0;
    for (int i = 0; i < FLAG_COUNT; i++) begin
      a           = FLAG_BASE + addr_t'(4 * i);
      exp_illegal = exp_illegal + int'(illegal_for(a));
      exp_err     = exp_err + int'(err_for(a));
    end
    if (illegal_seen != exp_illegal) begin
      value_error("illegal word count", exp_illegal, illegal_seen);
    end
    if (err_seen != exp_err) begin
      value_error("error word count", exp_err, err_seen);
    end
    finish_test();

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
logic/fetch_pkg.sv
logic/fetch_unit.sv
logic/prefetch_fifo.sv
logic/instr_issue.sv
logic/fetch_top.sv
tests/tb_clock_gen.sv
tests/tb_instr_mem.sv
tests/tb_fetch_top.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch path testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_fetch_top -Wno-fatal -f filelist.f -o sim_fetch_top \
  && ./obj_dir/sim_fetch_top > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0
